/* verilog.f */
uart_cfg_pkg.sv
uart_frame_pkg.sv
uart_clk_div.sv
uart_tx.sv
uart_rx.sv
uart_link_ctrl.sv
uart_top.sv
tb_clk_gen.sv
uart_assertions.sv
uart_tb.sv

/* Makefile */
TOP := uart_tb

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | awk '{ print } /^Test completed successfully$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* uart_tb.sv */
`timescale 1ns/10ps

module uart_tb
  import uart_cfg_pkg::*, uart_frame_pkg::*;
();

  // one expected frame, as the receiver should report it
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  par_err;
    logic                  stop_err;
  } exp_frame_t;

  logic                  clk;
  logic                  rst_n;
  uart_cfg_t             cfg;
  logic                  tx_start;
  logic [DATA_WIDTH-1:0] tx_data;
  logic                  err_clr;
  logic                  loop_sel;           // 1 = rx fed back from tx
  logic                  bb_line;            // bit-banged serial line
  logic                  loop_line = 1'b1;   // tx line re-timed to the drive point
  logic                  rx_line;
  logic                  tx_serial;
  logic [DATA_WIDTH-1:0] rx_data;
  link_status_t          status;

  exp_frame_t exp_q[$];          // model of bytes still in flight
  logic       exp_par_sticky;
  logic       exp_stop_sticky;
  int         rx_seen;           // rx valid pulses so far
  int         check_count;
  int         error_count;
  int         timeout_count;
  integer     seed;

  tb_clk_gen u_clk_gen (
    .o_clk (clk)
  );

  uart_top UUT (
    .i_clk_div_ref_clk (clk),
    .i_clk_div_rst_n   (rst_n),
    .i_cfg             (cfg),
    .i_tx_start        (tx_start),
    .i_tx_data         (tx_data),
    .i_err_clr         (err_clr),
    .i_rx_serial       (rx_line),
    .o_tx_serial       (tx_serial),
    .o_rx_data         (rx_data),
    .o_status          (status)
  );

  // loopback also changes 2 ns after the edge, never with a divided clock edge
  always @(posedge clk)
  begin
    #2;
    loop_line = tx_serial;
  end

  assign rx_line = loop_sel ? loop_line : bb_line;

  function automatic logic [31:0] draw_random();
    draw_random = $random(seed);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] draw_byte();
    logic [31:0] r;
    r = draw_random();
    return r[DATA_WIDTH-1:0];
  endfunction

  function automatic logic [PRESCALE_WIDTH-1:0] draw_prescale();
    logic [31:0] r;
    r = draw_random();
    return 8'd2 + {6'd0, r[1:0]};   // 2..5
  endfunction

  // bit that makes the ones count even, or odd with odd set
  function automatic logic parity_bit(input logic [DATA_WIDTH-1:0] data, input logic odd);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < DATA_WIDTH; i++)
      ones += int'(data[i]);
    return ((ones % 2) == 1) ? ~odd : odd;
  endfunction

  function automatic int bit_cycles();
    return int'(cfg.prescale) * OVERSAMPLE;   // ref cycles per bit
  endfunction

  function automatic int frame_timeout();
    return 3 * 11 * bit_cycles() + 200;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got,
                             input logic [7:0] expected);
    check_count++;
    if (got !== expected)
    begin
      $display("[ERROR] %s got 0x%02h expected 0x%02h at %0t", name, got, expected, $time);
      error_count++;
    end
  endtask

  // compare one received byte against the head of the model
  task automatic check_rx_frame();
    exp_frame_t want;
    rx_seen++;
    if (exp_q.size() == 0)
    begin
      $display("rx valid pulse with no byte expected at %0t", $time);
      error_count++;
    end
    else
    begin
      want            = exp_q.pop_front();
      exp_par_sticky  = exp_par_sticky | want.par_err;
      exp_stop_sticky = exp_stop_sticky | want.stop_err;
      check_value("o_rx_data", rx_data, want.data);
      check_value("o_status.par_err", 8'(status.par_err), 8'(exp_par_sticky));
      check_value("o_status.stop_err", 8'(status.stop_err), 8'(exp_stop_sticky));
    end
  endtask

  // one ref cycle, lands on the drive point and watches rx valid
  task automatic step();
    @(posedge clk);
    #2;
    if (rst_n && status.rx_valid)
      check_rx_frame();
  endtask

  task automatic step_n(input int n);
    int i;
    for (i = 0; i < n; i++)
      step();
  endtask

  task automatic wait_tx_idle();
    int cnt;
    cnt = 0;
    while (status.tx_busy && (cnt < frame_timeout()))
    begin
      step();
      cnt++;
    end
    if (status.tx_busy)
    begin
      $display("timeout waiting for tx busy to fall");
      timeout_count++;
    end
  endtask

  task automatic wait_rx_drain();
    int cnt;
    cnt = 0;
    while ((exp_q.size() != 0) && (cnt < frame_timeout()))
    begin
      step();
      cnt++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout waiting for rx valid, %0d bytes outstanding", exp_q.size());
      timeout_count++;
      exp_q.delete();
    end
  endtask

  task automatic check_idle();
    check_value("o_tx_serial", 8'(tx_serial), 8'h01);
    check_value("o_status", 8'(status), {6'd0, exp_par_sticky, exp_stop_sticky});
  endtask

  // cfg only moves while en is low
  task automatic configure(input logic par_en, input logic par_odd,
                           input logic [PRESCALE_WIDTH-1:0] prescale, input logic loopback);
    wait_tx_idle();
    cfg.en = 1'b0;
    step_n(4);
    check_idle();
    cfg.par_en   = par_en;
    cfg.par_odd  = par_odd;
    cfg.prescale = prescale;
    loop_sel     = loopback;
    step_n(4);
    cfg.en = 1'b1;
    step_n(4 * bit_cycles());   // dividers settle, line idles high
  endtask

  task automatic send_byte(input logic [DATA_WIDTH-1:0] data);
    exp_frame_t want;
    wait_tx_idle();
    tx_data  = data;
    tx_start = 1'b1;
    step();
    tx_start = 1'b0;
    check_value("o_status.tx_busy", 8'(status.tx_busy), 8'h01);   // 1 cycle after start
    want.data     = data;
    want.par_err  = 1'b0;
    want.stop_err = 1'b0;
    exp_q.push_back(want);
  endtask

  task automatic drive_bit(input logic value, input int cycles);
    bb_line = value;
    step_n(cycles);
  endtask

  task automatic bitbang_frame(input logic [DATA_WIDTH-1:0] data, input logic flip_par,
                               input logic stop_bit);
    exp_frame_t want;
    int         i;
    want.data     = data;
    want.par_err  = cfg.par_en & flip_par;
    want.stop_err = ~stop_bit;
    exp_q.push_back(want);
    drive_bit(1'b0, bit_cycles());                  // start
    for (i = 0; i < DATA_WIDTH; i++)
      drive_bit(data[i], bit_cycles());             // lsb first
    if (cfg.par_en)
      drive_bit(parity_bit(data, cfg.par_odd) ^ flip_par, bit_cycles());
    drive_bit(stop_bit, bit_cycles());
    drive_bit(1'b1, 2 * bit_cycles());              // idle gap
  endtask

  task automatic clear_errors();
    err_clr = 1'b1;
    step();
    err_clr         = 1'b0;
    exp_par_sticky  = 1'b0;
    exp_stop_sticky = 1'b0;
    check_value("o_status.par_err", 8'(status.par_err), 8'h00);
    check_value("o_status.stop_err", 8'(status.stop_err), 8'h00);
  endtask

  initial
  begin
    logic [31:0] r;
    int          i;
    int          seen;
    seed            = 32'hb3b8;
    rst_n           = 1'b0;
    cfg             = '0;
    tx_start        = 1'b0;
    tx_data         = '0;
    err_clr         = 1'b0;
    loop_sel        = 1'b0;
    bb_line         = 1'b1;
    exp_par_sticky  = 1'b0;
    exp_stop_sticky = 1'b0;
    rx_seen         = 0;
    check_count     = 0;
    error_count     = 0;
    timeout_count   = 0;

    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step_n(4);
    check_idle();   // reset values with en low

    // loopback, no parity
    configure(1'b0, 1'b0, draw_prescale(), 1'b1);
    for (i = 0; i < 6; i++)
    begin
      send_byte(draw_byte());
      wait_rx_drain();
    end

    // loopback, even then odd parity
    configure(1'b1, 1'b0, draw_prescale(), 1'b1);
    for (i = 0; i < 6; i++)
    begin
      send_byte(draw_byte());
      wait_rx_drain();
    end
    configure(1'b1, 1'b1, draw_prescale(), 1'b1);
    for (i = 0; i < 6; i++)
    begin
      send_byte(draw_byte());
      wait_rx_drain();
    end

    // injected frames, clean then bad parity then low stop
    r = draw_random();
    configure(1'b1, r[0], draw_prescale(), 1'b0);
    bitbang_frame(draw_byte(), 1'b0, 1'b1);
    wait_rx_drain();
    bitbang_frame(draw_byte(), 1'b1, 1'b1);
    wait_rx_drain();
    check_value("o_status.par_err", 8'(status.par_err), 8'h01);
    bitbang_frame(draw_byte(), 1'b0, 1'b0);
    wait_rx_drain();
    check_value("o_status.stop_err", 8'(status.stop_err), 8'h01);
    clear_errors();

    // start while busy is dropped
    configure(1'b0, 1'b0, draw_prescale(), 1'b1);
    send_byte(draw_byte());
    tx_data  = ~tx_data;
    tx_start = 1'b1;
    step();
    tx_start = 1'b0;
    check_value("o_status.tx_busy", 8'(status.tx_busy), 8'h01);
    wait_rx_drain();
    wait_tx_idle();
    seen = rx_seen;
    step_n(11 * bit_cycles());
    check_value("extra rx valid pulses", 8'(rx_seen - seen), 8'h00);

    // short low glitch, then a good frame to show recovery
    configure(1'b0, 1'b0, draw_prescale(), 1'b0);
    seen = rx_seen;
    drive_bit(1'b0, bit_cycles() / 4);
    drive_bit(1'b1, 11 * bit_cycles());
    check_value("rx valid pulses after glitch", 8'(rx_seen - seen), 8'h00);
    bitbang_frame(draw_byte(), 1'b0, 1'b1);
    wait_rx_drain();

    // disabled link is quiet
    wait_tx_idle();
    cfg.en = 1'b0;
    step_n(8);
    check_idle();

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0))
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* uart_assertions.sv */
`timescale 1ns/10ps

module uart_assertions
  import uart_frame_pkg::*;
(
  input logic         i_clk_div_ref_clk,
  input logic         i_clk_div_rst_n,
  input logic         i_err_clr,
  input logic         i_tx_done_chg,   // synchronized done toggle changed
  input link_status_t i_status
);

  // one pulse per received frame
  rx_valid_single: assert property (
    @(posedge i_clk_div_ref_clk) disable iff (!i_clk_div_rst_n)
    i_status.rx_valid |=> !i_status.rx_valid
  ) else $error("rx valid high for two cycles in a row");

  // busy only drops once the transmitter reported its stop bit
  busy_fall_on_done: assert property (
    @(posedge i_clk_div_ref_clk) disable iff (!i_clk_div_rst_n)
    $fell(i_status.tx_busy) |-> $past(i_tx_done_chg)
  ) else $error("tx busy fell without a done toggle change");

  // sticky flags only clear through i_err_clr
  par_err_clear: assert property (
    @(posedge i_clk_div_ref_clk) disable iff (!i_clk_div_rst_n)
    $fell(i_status.par_err) |-> $past(i_err_clr)
  ) else $error("sticky parity error fell without i_err_clr");

  stop_err_clear: assert property (
    @(posedge i_clk_div_ref_clk) disable iff (!i_clk_div_rst_n)
    $fell(i_status.stop_err) |-> $past(i_err_clr)
  ) else $error("sticky stop error fell without i_err_clr");

endmodule

bind uart_link_ctrl uart_assertions u_assertions (
  .i_clk_div_ref_clk (i_clk_div_ref_clk),
  .i_clk_div_rst_n   (i_clk_div_rst_n),
  .i_err_clr         (i_err_clr),
  .i_tx_done_chg     (tx_done_chg),
  .i_status          (o_status)
);

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen
(
  output logic o_clk
);

  // 20 ns period, starts low
  initial
  begin
    o_clk = 1'b0;
    forever
    begin
      #10 o_clk = ~o_clk;  // half period
    end
  end

endmodule

/* uart_top.sv */
`timescale 1ns/10ps

module uart_top
  import uart_cfg_pkg::*, uart_frame_pkg::*;
(
  input  logic                  i_clk_div_ref_clk,
  input  logic                  i_clk_div_rst_n,
  input  uart_cfg_t             i_cfg,
  input  logic                  i_tx_start,
  input  logic [DATA_WIDTH-1:0] i_tx_data,
  input  logic                  i_err_clr,
  input  logic                  i_rx_serial,
  output logic                  o_tx_serial,
  output logic [DATA_WIDTH-1:0] o_rx_data,
  output link_status_t          o_status
);

  logic [RATIO_WIDTH-1:0] rx_ratio;     // oversample divide, prescale as is
  logic [RATIO_WIDTH-1:0] tx_ratio;     // baud divide, prescale * 8
  logic                   tx_baud_clk;
  logic                   rx_os_clk;
  tx_req_t                tx_req;
  logic                   tx_done_tgl;
  rx_result_t             rx_result;

  assign rx_ratio = {{(RATIO_WIDTH-PRESCALE_WIDTH){1'b0}}, i_cfg.prescale};
  assign tx_ratio = rx_ratio << OVERSAMPLE_LOG2;

  uart_clk_div u_tx_div (
    .i_clk_div_ref_clk  (i_clk_div_ref_clk),
    .i_clk_div_rst_n    (i_clk_div_rst_n),
    .i_clk_div_clk_en   (i_cfg.en),
    .i_clk_div_ratio    (tx_ratio),
    .o_clk_div_baud_clk (tx_baud_clk)
  );

  uart_clk_div u_rx_div (
    .i_clk_div_ref_clk  (i_clk_div_ref_clk),
    .i_clk_div_rst_n    (i_clk_div_rst_n),
    .i_clk_div_clk_en   (i_cfg.en),
    .i_clk_div_ratio    (rx_ratio),
    .o_clk_div_baud_clk (rx_os_clk)
  );

  uart_tx u_tx (
    .i_clk_div_ref_clk (tx_baud_clk),
    .i_clk_div_rst_n   (i_clk_div_rst_n),
    .i_cfg             (i_cfg),
    .i_tx_req          (tx_req),
    .o_tx_done_tgl     (tx_done_tgl),
    .o_tx_serial       (o_tx_serial)
  );

  uart_rx u_rx (
    .i_clk_div_ref_clk (rx_os_clk),
    .i_clk_div_rst_n   (i_clk_div_rst_n),
    .i_cfg             (i_cfg),
    .i_rx_serial       (i_rx_serial),
    .o_rx_result       (rx_result)
  );

  uart_link_ctrl u_link_ctrl (
    .i_clk_div_ref_clk (i_clk_div_ref_clk),
    .i_clk_div_rst_n   (i_clk_div_rst_n),
    .i_tx_start        (i_tx_start),
    .i_tx_data         (i_tx_data),
    .i_err_clr         (i_err_clr),
    .i_tx_done_tgl     (tx_done_tgl),
    .i_rx_result       (rx_result),
    .o_tx_req          (tx_req),
    .o_rx_data         (o_rx_data),
    .o_status          (o_status)
  );

endmodule

/* uart_link_ctrl.sv */
`timescale 1ns/10ps

module uart_link_ctrl
  import uart_cfg_pkg::*, uart_frame_pkg::*;
(
  input  logic                  i_clk_div_ref_clk,
  input  logic                  i_clk_div_rst_n,
  input  logic                  i_tx_start,
  input  logic [DATA_WIDTH-1:0] i_tx_data,
  input  logic                  i_err_clr,
  input  logic                  i_tx_done_tgl,
  input  rx_result_t            i_rx_result,
  output tx_req_t               o_tx_req,
  output logic [DATA_WIDTH-1:0] o_rx_data,
  output link_status_t          o_status
);

  logic                  tx_busy;
  logic                  tx_accept;      // start taken this cycle
  logic                  req_tgl;
  logic [DATA_WIDTH-1:0] req_data;       // stable while busy
  logic [2:0]            tx_done_sync;   // [1:0] sync stages, [2] previous value
  logic                  tx_done_chg;
  logic [2:0]            rx_done_sync;
  logic                  rx_done_chg;
  logic                  rx_valid;
  logic                  par_err_sticky;
  logic                  stop_err_sticky;

  assign tx_accept   = i_tx_start && !tx_busy;   // starts while busy are dropped
  assign tx_done_chg = tx_done_sync[2] ^ tx_done_sync[1];
  assign rx_done_chg = rx_done_sync[2] ^ rx_done_sync[1];

  // latched byte that the transmitter loads after the toggle
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    if (tx_accept)
      req_data <= i_tx_data;
  end

  // rx byte is stable in the rx domain once its toggle has flipped
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    if (rx_done_chg)
      o_rx_data <= i_rx_result.data;
  end

  always_ff @(posedge i_clk_div_ref_clk or negedge i_clk_div_rst_n)
  begin
    if (!i_clk_div_rst_n)
    begin
      tx_busy         <= 1'b0;
      req_tgl         <= 1'b0;
      tx_done_sync    <= '0;
      rx_done_sync    <= '0;
      rx_valid        <= 1'b0;
      par_err_sticky  <= 1'b0;
      stop_err_sticky <= 1'b0;
    end
    else
    begin
      tx_done_sync <= {tx_done_sync[1:0], i_tx_done_tgl};
      rx_done_sync <= {rx_done_sync[1:0], i_rx_result.done_tgl};

      if (tx_accept)
      begin
        req_tgl <= ~req_tgl;
        tx_busy <= 1'b1;
      end
      else if (tx_done_chg)
        tx_busy <= 1'b0;               // transmitter reported its stop bit

      rx_valid <= rx_done_chg;         // single cycle per frame

      // set wins over a clear in the same cycle
      if (rx_done_chg && i_rx_result.par_err)
        par_err_sticky <= 1'b1;
      else if (i_err_clr)
        par_err_sticky <= 1'b0;

      if (rx_done_chg && i_rx_result.stop_err)
        stop_err_sticky <= 1'b1;
      else if (i_err_clr)
        stop_err_sticky <= 1'b0;
    end
  end

  always_comb
  begin
    o_tx_req.req_tgl  = req_tgl;
    o_tx_req.data     = req_data;
    o_status.tx_busy  = tx_busy;
    o_status.rx_valid = rx_valid;
    o_status.par_err  = par_err_sticky;
    o_status.stop_err = stop_err_sticky;
  end

endmodule

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx
  import uart_cfg_pkg::*, uart_frame_pkg::*;
(
  input  logic       i_clk_div_ref_clk,  // oversample clock, 8 ticks per bit
  input  logic       i_clk_div_rst_n,
  input  uart_cfg_t  i_cfg,
  input  logic       i_rx_serial,
  output rx_result_t o_rx_result
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t                  state;
  logic [2:0]                 rx_sync;     // [1:0] sync stages, [2] previous value
  logic                       rx_bit;      // synchronized line
  logic                       rx_fall;     // high to low on the line
  logic [OVERSAMPLE_LOG2-1:0] samp_cnt;    // tick inside the current bit
  logic                       mid_sample;
  logic                       bit_end;
  logic [BIT_CNT_WIDTH-1:0]   bit_cnt;
  logic [DATA_WIDTH-1:0]      shift;       // bits arrive lsb first
  logic                       par_bad;     // parity bit disagrees with data
  logic                       done_tgl;
  logic [DATA_WIDTH-1:0]      data_q;      // held until the next frame ends
  logic                       par_err_q;
  logic                       stop_err_q;

  assign rx_bit     = rx_sync[1];
  assign rx_fall    = rx_sync[2] & ~rx_sync[1];
  assign mid_sample = (samp_cnt == OVERSAMPLE_LOG2'(SAMPLE_MID));
  assign bit_end    = (samp_cnt == '1);

  always_ff @(posedge i_clk_div_ref_clk or negedge i_clk_div_rst_n)
  begin
    if (!i_clk_div_rst_n)
    begin
      rx_sync  <= '1;   // idle line, no false edge out of reset
      state    <= RX_IDLE;
      samp_cnt <= '0;
      bit_cnt  <= '0;
      done_tgl <= 1'b0;
    end
    else
    begin
      rx_sync <= {rx_sync[1:0], i_rx_serial};
      if (state != RX_IDLE)
        samp_cnt <= samp_cnt + 1'b1;     // wraps every bit
      case (state)
        RX_IDLE:
        begin
          samp_cnt <= '0;
          if (rx_fall)
            state <= RX_START;
        end
        RX_START:
        begin
          if (mid_sample && rx_bit)      // high in the middle, a glitch
            state <= RX_IDLE;
          else if (bit_end)
          begin
            state   <= RX_DATA;
            bit_cnt <= '0;
          end
        end
        RX_DATA:
        begin
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == '1)
              state <= i_cfg.par_en ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY:
        begin
          if (bit_end)
            state <= RX_STOP;
        end
        RX_STOP:
        begin
          // report at the stop bit middle, back to idle in time for the next start
          if (mid_sample)
          begin
            state    <= RX_IDLE;
            done_tgl <= ~done_tgl;
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // data path, everything taken at the bit middle
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    if (mid_sample)
    begin
      case (state)
        RX_DATA:
          shift <= {rx_bit, shift[DATA_WIDTH-1:1]};
        RX_PARITY:
          par_bad <= rx_bit ^ (^shift) ^ i_cfg.par_odd;
        RX_STOP:
        begin
          data_q     <= shift;
          par_err_q  <= i_cfg.par_en & par_bad;   // stale par_bad masked off
          stop_err_q <= ~rx_bit;
        end
        default:
        begin
        end
      endcase
    end
  end

  always_comb
  begin
    o_rx_result.done_tgl = done_tgl;
    o_rx_result.data     = data_q;
    o_rx_result.par_err  = par_err_q;
    o_rx_result.stop_err = stop_err_q;
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx
  import uart_cfg_pkg::*, uart_frame_pkg::*;
(
  input  logic      i_clk_div_ref_clk,   // baud clock from the tx divider
  input  logic      i_clk_div_rst_n,
  input  uart_cfg_t i_cfg,
  input  tx_req_t   i_tx_req,
  output logic      o_tx_done_tgl,
  output logic      o_tx_serial
);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  tx_state_t                state;
  logic [2:0]               req_sync;   // [1:0] sync stages, [2] previous value
  logic                     req_edge;   // new request seen in the baud domain
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;    // data bit on the line
  logic [DATA_WIDTH-1:0]    shift;      // remaining data bits, lsb next
  logic                     par_bit;
  logic                     done_tgl;

  assign req_edge = req_sync[2] ^ req_sync[1];

  // load byte and parity together, then shift lsb first
  always_ff @(posedge i_clk_div_ref_clk)
  begin
    if ((state == TX_IDLE) && req_edge)
    begin
      shift   <= i_tx_req.data;
      par_bit <= (^i_tx_req.data) ^ i_cfg.par_odd;  // even: total ones stay even
    end
    else if ((state == TX_START) || (state == TX_DATA))
    begin
      shift <= shift >> 1;
    end
  end

  always_ff @(posedge i_clk_div_ref_clk or negedge i_clk_div_rst_n)
  begin
    if (!i_clk_div_rst_n)
    begin
      req_sync    <= '0;
      state       <= TX_IDLE;
      bit_cnt     <= '0;
      o_tx_serial <= 1'b1;   // line idles high
      done_tgl    <= 1'b0;
    end
    else
    begin
      req_sync <= {req_sync[1:0], i_tx_req.req_tgl};
      case (state)
        TX_IDLE:
        begin
          if (req_edge)
          begin
            state       <= TX_START;
            o_tx_serial <= 1'b0;          // start bit
          end
        end
        TX_START:
        begin
          state       <= TX_DATA;
          bit_cnt     <= '0;
          o_tx_serial <= shift[0];        // bit 0
        end
        TX_DATA:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == '1)              // last data bit done
          begin
            state       <= i_cfg.par_en ? TX_PARITY : TX_STOP;
            o_tx_serial <= i_cfg.par_en ? par_bit : 1'b1;
          end
          else
          begin
            o_tx_serial <= shift[0];
          end
        end
        TX_PARITY:
        begin
          state       <= TX_STOP;
          o_tx_serial <= 1'b1;            // stop bit
        end
        TX_STOP:
        begin
          state    <= TX_IDLE;
          done_tgl <= ~done_tgl;          // frame finished
        end
        default:
        begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  assign o_tx_done_tgl = done_tgl;

endmodule

/* uart_clk_div.sv */
`timescale 1ns/10ps

module uart_clk_div
  import uart_cfg_pkg::*;
(
  input  logic                   i_clk_div_ref_clk,
  input  logic                   i_clk_div_rst_n,
  input  logic                   i_clk_div_clk_en,
  input  logic [RATIO_WIDTH-1:0] i_clk_div_ratio,
  output logic                   o_clk_div_baud_clk
);

  logic [RATIO_WIDTH-1:0] cnt;          // ref edges since the last toggle
  logic [RATIO_WIDTH-1:0] half;         // ratio / 2, rounded down
  logic [RATIO_WIDTH-1:0] half_m1;      // terminal count of a short phase
  logic                   phase_flag;   // the divided clock, also marks high/low phase
  logic                   div_en;       // divider really running
  logic                   ratio_odd;
  logic                   tgl_even;
  logic                   tgl_odd_hi;   // end of the short high phase
  logic                   tgl_odd_lo;   // end of the long low phase
  logic                   tgl;

  // ratio 0 and 1 cannot be divided, fall back to the ref clock
  assign div_en = i_clk_div_clk_en &&
                  (i_clk_div_ratio != '0) &&
                  (i_clk_div_ratio != RATIO_WIDTH'(1));

  assign ratio_odd = i_clk_div_ratio[0];
  assign half      = i_clk_div_ratio >> 1;
  assign half_m1   = half - 1'b1;

  // even: both phases last N/2 edges
  assign tgl_even   = !ratio_odd && (cnt == half_m1);
  // odd: high for (N-1)/2 edges, low for (N+1)/2 edges
  assign tgl_odd_hi = ratio_odd && phase_flag && (cnt == half_m1);
  assign tgl_odd_lo = ratio_odd && !phase_flag && (cnt == half);
  assign tgl        = tgl_even || tgl_odd_hi || tgl_odd_lo;

  always_ff @(posedge i_clk_div_ref_clk or negedge i_clk_div_rst_n)
  begin
    if (!i_clk_div_rst_n)
    begin
      cnt        <= '0;
      phase_flag <= 1'b0;
    end
    else if (div_en)
    begin
      if (tgl)
      begin
        phase_flag <= ~phase_flag;   // next half period
        cnt        <= '0;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
    else
    begin
      // parked low so a later enable starts with a full low phase
      cnt        <= '0;
      phase_flag <= 1'b0;
    end
  end

  // pass-through when disabled or ratio 0/1
  assign o_clk_div_baud_clk = div_en ? phase_flag : i_clk_div_ref_clk;

endmodule

/* uart_frame_pkg.sv */
package uart_frame_pkg;

  import uart_cfg_pkg::*;

  // link ctrl -> transmitter, data is stable while the toggle is in flight
  typedef struct packed {
    logic                  req_tgl;  // flips once per requested frame
    logic [DATA_WIDTH-1:0] data;     // byte to send
  } tx_req_t;

  // receiver -> link ctrl, fields held until the next frame completes
  typedef struct packed {
    logic                  done_tgl;  // flips once per received frame
    logic [DATA_WIDTH-1:0] data;      // received byte
    logic                  par_err;   // parity mismatch, only with par_en
    logic                  stop_err;  // stop bit sampled low
  } rx_result_t;

  // status seen at the top level
  typedef struct packed {
    logic tx_busy;    // frame in flight on the transmit side
    logic rx_valid;   // one ref cycle pulse per received byte
    logic par_err;    // sticky, cleared by i_err_clr
    logic stop_err;   // sticky, cleared by i_err_clr
  } link_status_t;

endpackage

/* uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // frame and divider widths
  localparam int DATA_WIDTH      = 8;   // data bits per frame
  localparam int PRESCALE_WIDTH  = 8;   // prescale field of the config
  localparam int RATIO_WIDTH     = 12;  // holds prescale << 3
  localparam int OVERSAMPLE_LOG2 = 3;   // 8 samples per bit

  // derived values
  localparam int OVERSAMPLE    = 1 << OVERSAMPLE_LOG2;
  localparam int SAMPLE_MID    = OVERSAMPLE / 2;       // sample point inside a bit
  localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);   // counts 0..7

  // link setup, only changed while en is low
  typedef struct packed {
    logic                      en;        // enables both dividers
    logic                      par_en;    // parity bit present
    logic                      par_odd;   // 1 = odd parity, 0 = even
    logic [PRESCALE_WIDTH-1:0] prescale;  // ref cycles per oversample tick
  } uart_cfg_t;

endpackage
